// File: mem_settings.svh
// Memory subsystem sizing
// Geometry of the chip array behind the Wishbone controller.
// Two banks, four 1024 x 4 chips per bank, giving 2048 x 16.
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Number of banks, each one bus word wide
`define MEM_BANKS 2

// Chips side by side in one word
`define CHIPS_PER_BANK 4

// Words per chip
`define CHIP_DEPTH 1024

// Data width of one chip
`define NIBBLE_W 4

`endif

// File: mem_types_pkg.sv
// Memory-side types
// Widths of the chip address, chip data, bus word and bank selects,
// all derived from the array geometry.
`include "mem_settings.svh"

package mem_types_pkg;

    // Word address inside one chip
    typedef logic [$clog2(`CHIP_DEPTH)-1:0] chip_addr_t;

    // Data of one chip
    typedef logic [`NIBBLE_W-1:0] nibble_t;

    // One bus word, all chips of a bank together
    typedef logic [`NIBBLE_W*`CHIPS_PER_BANK-1:0] word_t;

    // One select per bank, active low
    typedef logic [`MEM_BANKS-1:0] bank_sel_t;

endpackage

// File: wb_pkg.sv
// Bus-side types
// Wishbone address layout and the controller state encoding.
`include "mem_settings.svh"

package wb_pkg;

    // Control flag, bank field, chip address
    typedef logic [$clog2(`CHIP_DEPTH)+$clog2(`MEM_BANKS):0] wb_addr_t;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,  // Waiting for stb
        ACK    = 2'd1,  // One-cycle acknowledge
        CLEAR1 = 2'd2,  // First clear cycle
        CLEAR2 = 2'd3   // Second clear cycle
    } ctrl_state_e;

endpackage

// File: sram_bus_if.sv
// Chip bus between controller and array
// Address, write data and active-low strobes toward the chips,
// OR-combined read data back to the controller.
`timescale 1ns/1ps

interface sram_bus_if;
    import mem_types_pkg::*;

    chip_addr_t address;          // Shared by every chip
    word_t      data_in;          // Nibble k goes to chip k
    bank_sel_t  chip_select_n;    // One per bank
    logic       write_enable_n;
    logic       output_enable_n;
    logic       mem_clear_n;      // Chip clear pin, not the system reset
    word_t      data_out;         // Registered read data

    // Controller side
    modport ctrl (
        output address, data_in, chip_select_n,
        output write_enable_n, output_enable_n, mem_clear_n,
        input  data_out
    );

    // Chip array side
    modport array (
        input  address, data_in, chip_select_n,
        input  write_enable_n, output_enable_n, mem_clear_n,
        output data_out
    );

endinterface

// File: am9150.sv
// Am9150-style 1024 x 4 static RAM, clocked model
// Separate data in and out, registered read and whole-array clear.
// Clear needs chip select and clear_n low together.
// An idle chip outputs zero so outputs can be ORed.
`timescale 1ns/1ps
`include "mem_settings.svh"

module am9150 (
    input  logic                      clk,
    input  mem_types_pkg::chip_addr_t address,
    input  mem_types_pkg::nibble_t    data_in,
    output mem_types_pkg::nibble_t    data_out,
    input  logic                      write_enable_n,
    input  logic                      chip_select_n,
    input  logic                      output_enable_n,
    input  logic                      clear_n
);
    import mem_types_pkg::*;

    nibble_t mem [`CHIP_DEPTH];  // Cell array, no power-up value
    logic    rd_en;

    // Read only when nothing else is going on
    assign rd_en = !chip_select_n && !output_enable_n && write_enable_n && clear_n;

    // Clear has priority over write
    always_ff @(posedge clk) begin
        if (!chip_select_n) begin
            if (!clear_n) begin
                for (int i = 0; i < `CHIP_DEPTH; i++) begin
                    mem[i] <= '0;
                end
            end else if (!write_enable_n) begin
                mem[address] <= data_in;  // Normal write
            end
        end
    end

    // Output register, zero stands in for high impedance
    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_out <= mem[address];
        end else begin
            data_out <= '0;
        end
    end

endmodule

// File: sram_array.sv
// Chip array, 2 banks x 4 Am9150 chips
// Every chip sees the shared address and strobes; the bank's own
// select picks the bank. Chip k of a bank holds nibble k of the word.
// Idle chips output zero, so the banks are merged with an OR.
`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_array (
    input logic       clk,
    sram_bus_if.array bus
);
    import mem_types_pkg::*;

    word_t bank_rd [`MEM_BANKS];  // Assembled read word per bank
    word_t rd_or;

    genvar b, c;
    generate
        for (b = 0; b < `MEM_BANKS; b++) begin : g_bank
            for (c = 0; c < `CHIPS_PER_BANK; c++) begin : g_chip
                am9150 u_chip (
                    .clk             (clk),
                    .address         (bus.address),
                    .data_in         (bus.data_in[c*`NIBBLE_W +: `NIBBLE_W]),
                    .data_out        (bank_rd[b][c*`NIBBLE_W +: `NIBBLE_W]),
                    .write_enable_n  (bus.write_enable_n),
                    .chip_select_n   (bus.chip_select_n[b]),  // Per-bank select
                    .output_enable_n (bus.output_enable_n),
                    .clear_n         (bus.mem_clear_n)
                );
            end
        end
    endgenerate

    // Wired-OR of the bank outputs
    always_comb begin
        rd_or = '0;
        for (int i = 0; i < `MEM_BANKS; i++) begin
            rd_or = rd_or | bank_rd[i];
        end
    end

    assign bus.data_out = rd_or;

endmodule

// File: wb_sram_ctrl.sv
// Wishbone classic slave for the chip array
// Single reads and writes to memory space ack after one cycle.
// A control-space write with data bit 0 set runs two clear cycles
// on every chip before the ack. Other control accesses just ack.
// Chip strobes are combinational from IDLE and stb.
`timescale 1ns/1ps
`include "mem_settings.svh"

module wb_sram_ctrl (
    input  logic                   clk,
    input  logic                   RESET_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  wb_pkg::wb_addr_t       wb_adr,
    input  mem_types_pkg::word_t   wb_dat_w,
    output mem_types_pkg::word_t   wb_dat_r,
    output logic                   wb_ack,
    sram_bus_if.ctrl               bus
);
    import mem_types_pkg::*;
    import wb_pkg::*;

    localparam int CA_W   = $clog2(`CHIP_DEPTH);  // Chip address bits
    localparam int BANK_W = $clog2(`MEM_BANKS);   // Bank field bits

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        ack_q;
    logic        req;       // Valid request on the bus
    logic        is_ctrl;   // Top address bit, control space
    bank_sel_t   bank_dec;  // One-hot bank, active high

    assign req     = wb_cyc && wb_stb;
    assign is_ctrl = wb_adr[CA_W+BANK_W];
    assign bank_dec = bank_sel_t'(1) << wb_adr[CA_W +: BANK_W];

    // Address and data go straight through
    assign bus.address = wb_adr[CA_W-1:0];
    assign bus.data_in = wb_dat_w;

    // Next state and chip strobes
    always_comb begin
        next_state          = state;
        bus.chip_select_n   = '1;    // Nothing selected by default
        bus.write_enable_n  = 1'b1;
        bus.output_enable_n = 1'b1;
        bus.mem_clear_n     = 1'b1;
        case (state)
            IDLE: begin
                if (req) begin
                    if (is_ctrl) begin
                        // Clear only on write with bit 0 set
                        next_state = (wb_we && wb_dat_w[0]) ? CLEAR1 : ACK;
                    end else begin
                        bus.chip_select_n   = ~bank_dec;
                        bus.write_enable_n  = !wb_we;
                        bus.output_enable_n = wb_we;   // Read enables outputs
                        next_state          = ACK;
                    end
                end
            end
            CLEAR1: begin
                bus.chip_select_n = '0;  // All banks at once
                bus.mem_clear_n   = 1'b0;
                next_state        = CLEAR2;
            end
            CLEAR2: begin
                bus.chip_select_n = '0;
                bus.mem_clear_n   = 1'b0;
                next_state        = ACK;
            end
            ACK: next_state = IDLE;  // Fresh IDLE before next transfer
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!RESET_n) begin
            state <= IDLE;
            ack_q <= 1'b0;
        end else begin
            state <= next_state;
            ack_q <= (next_state == ACK);  // High for the ACK cycle only
        end
    end

    assign wb_ack   = ack_q;
    assign wb_dat_r = bus.data_out;  // Zero unless a read was strobed

endmodule

// File: sram_subsystem.sv
// 2048 x 16 static memory subsystem
// Wishbone classic slave in front of eight 1024 x 4 chips.
// Address bit 11 selects control space, bit 10 the bank.
// A control write with data bit 0 set clears the whole array.
`timescale 1ns/1ps

module sram_subsystem (
    input  logic                 clk,
    input  logic                 RESET_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  wb_pkg::wb_addr_t     wb_adr,
    input  mem_types_pkg::word_t wb_dat_w,
    output mem_types_pkg::word_t wb_dat_r,
    output logic                 wb_ack
);

    // Chip bus between controller and array
    sram_bus_if mem_bus ();

    // Bus slave and strobe generation
    wb_sram_ctrl u_ctrl (
        .clk      (clk),
        .RESET_n  (RESET_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .bus      (mem_bus.ctrl)
    );

    // Eight chips, no system reset on the cells
    sram_array u_array (
        .clk (clk),
        .bus (mem_bus.array)
    );

endmodule

// File: sram_checker.sv
// Protocol checks bound into the Wishbone controller
// Ack is one cycle wide, strobes stay quiet in ACK,
// one bank at a time outside clear, and never a write and a read together.
`timescale 1ns/1ps

module sram_checker (
    input logic                      clk,
    input logic                      RESET_n,
    input logic                      wb_ack,
    input wb_pkg::ctrl_state_e       state,
    input mem_types_pkg::bank_sel_t  chip_select_n,
    input logic                      write_enable_n,
    input logic                      output_enable_n,
    input logic                      mem_clear_n
);
    import wb_pkg::*;
    import mem_types_pkg::*;

    // Single-cycle acknowledge
    ack_one_cycle: assert property (@(posedge clk) disable iff (!RESET_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for more than one cycle");

    // No chip select during the ACK state
    quiet_in_ack: assert property (@(posedge clk) disable iff (!RESET_n)
        (state == ACK) |-> (&chip_select_n))
        else $error("chip selected while in ACK");

    // Both banks only for the clear cycles
    one_bank: assert property (@(posedge clk) disable iff (!RESET_n)
        ($countones(~chip_select_n) > 1) |-> !mem_clear_n)
        else $error("two banks selected outside a clear");

    // Write and output enable exclusive
    we_oe_excl: assert property (@(posedge clk) disable iff (!RESET_n)
        !(!write_enable_n && !output_enable_n))
        else $error("write and output enable low together");

endmodule

// Attach to every controller instance
bind wb_sram_ctrl sram_checker u_checker (
    .clk             (clk),
    .RESET_n         (RESET_n),
    .wb_ack          (wb_ack),
    .state           (state),
    .chip_select_n   (bus.chip_select_n),
    .write_enable_n  (bus.write_enable_n),
    .output_enable_n (bus.output_enable_n),
    .mem_clear_n     (bus.mem_clear_n)
);

// File: tb_sram_subsystem.sv
// Testbench for the 2048 x 16 memory subsystem
// Seeded random Wishbone traffic checked against a word-array model,
// ack latency checks and the whole-array clear.
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_sram_subsystem;
    import mem_types_pkg::*;
    import wb_pkg::*;

    localparam int DEPTH       = `MEM_BANKS * `CHIP_DEPTH;
    localparam int ACK_TIMEOUT = 20;   // Cycles to wait for ack

    logic     clk;
    logic     RESET_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    word_t    wb_dat_w;
    word_t    wb_dat_r;
    logic     wb_ack;

    word_t    model [DEPTH];    // Reference memory
    wb_addr_t used_q [$];       // Addresses written in test 2
    int       checks;
    int       errors;
    int       chk_base;
    int       err_base;

    sram_subsystem UUT (
        .clk      (clk),
        .RESET_n  (RESET_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic check_word(input word_t got, input word_t exp, input wb_addr_t adr);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: read 0x%03h gave 0x%04h, expected 0x%04h", $time, adr, got, exp);
        end
    endtask

    task automatic check_ack_latency(input int got, input int exp, input wb_addr_t adr);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %0t: ack for 0x%03h after %0d cycles, expected %0d",
                     $time, adr, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Control write with bit 0 set takes the two clear cycles
    function automatic int expected_latency(input logic we, input wb_addr_t adr, input word_t dat);
        return (adr[11] && we && dat[0]) ? 3 : 1;
    endfunction

    function automatic word_t expected_read(input wb_addr_t adr);
        return adr[11] ? word_t'(0) : model[adr[10:0]];
    endfunction

    function automatic void model_write(input wb_addr_t adr, input word_t dat);
        if (!adr[11]) begin
            model[adr[10:0]] = dat;
        end else if (dat[0]) begin
            for (int i = 0; i < DEPTH; i++) begin
                model[i] = '0;  // Whole-array clear
            end
        end
    endfunction

    // Falling edges counted up to ack
    task automatic wait_ack(output int lat);
        logic seen;
        lat = 0;
        seen = 1'b0;
        while (!seen && lat < ACK_TIMEOUT) begin
            @(negedge clk);
            lat++;
            seen = wb_ack;
        end
        if (!seen) begin
            errors++;
            $display("Timeout: no ack for address 0x%03h within %0d cycles at %0t",
                     wb_adr, ACK_TIMEOUT, $time);
            lat = 0;  // Zero marks a timeout
        end
    endtask

    task automatic release_bus();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input word_t dat);
        int lat;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wait_ack(lat);
        release_bus();   // stb drops right after ack
        if (lat > 0) begin
            check_ack_latency(lat, expected_latency(1'b1, adr, dat), adr);
        end
        model_write(adr, dat);
    endtask

    task automatic wb_read(input wb_addr_t adr);
        int    lat;
        word_t rd;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(lat);
        rd = wb_dat_r;   // Valid while ack is high
        release_bus();
        if (lat > 0) begin
            check_ack_latency(lat, expected_latency(1'b0, adr, '0), adr);
            check_word(rd, expected_read(adr), adr);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s: %0d checks, %0d errors", name, checks - chk_base, errors - err_base);
        chk_base = checks;
        err_base = errors;
    endtask

    function automatic wb_addr_t rand_mem_addr();
        return wb_addr_t'($urandom % DEPTH);  // Bit 11 stays clear
    endfunction

    initial begin
        wb_addr_t a;
        void'($urandom(93));
        clk      = 1'b0;
        RESET_n  = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        release_bus();
        checks   = 0;
        errors   = 0;
        chk_base = 0;
        err_base = 0;
        repeat (16) @(negedge clk);
        RESET_n = 1'b1;

        // 1. Idle bus and single-cycle latency
        repeat (8) begin
            @(negedge clk);
            check_flag(wb_ack, 1'b0, "wb_ack while idle");
        end
        wb_write(12'h005, 16'hA5C3);
        wb_read(12'h005);
        end_test("1 ack latency");

        // 2. Random writes read back afterwards
        for (int i = 0; i < 300; i++) begin
            a = rand_mem_addr();
            used_q.push_back(a);
            wb_write(a, word_t'($urandom));
        end
        foreach (used_q[i]) begin
            wb_read(used_q[i]);
        end
        end_test("2 random write/read");

        // 3. Bank bit alone separates two words
        for (int i = 0; i < 20; i++) begin
            a = wb_addr_t'($urandom % `CHIP_DEPTH);
            wb_write(a, word_t'($urandom));
            wb_write(a | 12'h400, word_t'($urandom));
            wb_read(a);
            wb_read(a | 12'h400);
        end
        end_test("3 bank independence");

        // 4. Whole-array clear
        wb_write(12'h800, 16'h0001);
        for (int i = 0; i < DEPTH; i++) begin
            wb_read(wb_addr_t'(i));
        end
        end_test("4 clear");

        // 5. Control accesses that must not clear
        for (int i = 0; i < 10; i++) begin
            wb_write(rand_mem_addr(), word_t'($urandom) | 16'h8000);
        end
        wb_write(12'h800, 16'hFFFE);
        wb_read(12'h800);
        for (int i = 0; i < DEPTH; i++) begin
            wb_read(wb_addr_t'(i));
        end
        end_test("5 control no-op");

        // 6. Mixed traffic after the clear
        for (int i = 0; i < 400; i++) begin
            if ($urandom % 2 == 0) begin
                wb_write(rand_mem_addr(), word_t'($urandom));
            end else begin
                wb_read(rand_mem_addr());
            end
        end
        end_test("6 mixed random");

        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
mem_types_pkg.sv
wb_pkg.sv
sram_bus_if.sv
am9150.sv
sram_array.sv
wb_sram_ctrl.sv
sram_subsystem.sv
sram_checker.sv
tb_sram_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f build.f \
    --top-module tb_sram_subsystem -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_sram_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
